/* hdl/scratchpad_pkg.sv */
`default_nettype none

package scratchpad_pkg;

    localparam int NUM_BANKS   = 4;
    localparam int BANK_W      = 2;
    localparam int MAT_S_W     = 4;
    localparam int MAT_ID_W    = 6;
    localparam int ROW_W       = 64;
    localparam int ADDR_W      = 32;
    localparam int ROWS        = 4;
    localparam int INSTR_DEPTH = 4;

    localparam logic [1:0] OP_NOP  = 2'b00;
    localparam logic [1:0] OP_LOAD = 2'b01;
    localparam logic [1:0] OP_GEMM = 2'b11;

    localparam logic [1:0] MT_INPUT  = 2'd1;
    localparam logic [1:0] MT_WEIGHT = 2'd2;
    localparam logic [1:0] MT_PSUM   = 2'd3;

    typedef enum logic [1:0] {
        OPC_NOP  = OP_NOP,
        OPC_LOAD = OP_LOAD,
        OPC_GEMM = OP_GEMM
    } opcode_t;

    typedef enum logic [1:0] {
        TAG_INPUT  = MT_INPUT,
        TAG_WEIGHT = MT_WEIGHT,
        TAG_PSUM   = MT_PSUM
    } mat_t_t;

    // a matrix id carries the bank index in its upper bits.
    typedef struct packed {
        opcode_t             opcode;
        logic [MAT_ID_W-1:0] ls_mat;
        logic [ADDR_W-1:0]   ls_addr;
        logic [MAT_ID_W-1:0] in_mat;
        logic [MAT_ID_W-1:0] weight_mat;
        logic [MAT_ID_W-1:0] psum_mat;
        logic                new_weight;
    } instr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic              valid;
    } load_req_t;

    typedef struct packed {
        mat_t_t             mat_t;
        logic [MAT_S_W-1:0] mat_s;
        logic [1:0]         row_s;
        logic [ROW_W-1:0]   data;
    } row_rsp_t;

endpackage

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty,
    output logic     full
);

    payload_t                       mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]       wptr, rptr;
    logic [$clog2(DEPTH+1)-1:0]     count;
    logic                           do_push, do_pop;

    assign empty   = (count == '0);
    assign full    = (count == $bits(count)'(DEPTH));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign rdata   = mem[rptr];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= (wptr == $bits(wptr)'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= (rptr == $bits(rptr)'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            // a push and a pop together leave the fill level unchanged.
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wptr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/bank_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_memory
    import scratchpad_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  logic               wen,
    input  logic [MAT_S_W-1:0] wmat,
    input  logic [1:0]         wrow,
    input  logic [ROW_W-1:0]   wdata,
    input  logic [MAT_S_W-1:0] rmat,
    input  logic [1:0]         rrow,
    output logic [ROW_W-1:0]   rdata
);

    // one entry per row of every matrix slot in the bank.
    logic [ROW_W-1:0] mem [2**MAT_S_W][ROWS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int m = 0; m < 2**MAT_S_W; m++) begin
                for (int r = 0; r < ROWS; r++) begin
                    mem[m][r] <= '0;
                end
            end
        end else if (wen) begin
            mem[wmat][wrow] <= wdata;
        end
    end

    // reads bypass nothing; a row written this cycle is visible on the next.
    assign rdata = mem[rmat][rrow];

endmodule

`default_nettype wire

/* hdl/bank_access_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_access_fsm
    import scratchpad_pkg::*;
#(
    parameter int BANK_NUM = 0
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             instr_take,
    input  instr_t           head,
    input  logic             load_hit,
    input  logic [ROW_W-1:0] load_data,
    input  logic             row_ready,
    output logic             idle,
    output load_req_t        load_req,
    output logic             row_valid,
    output row_rsp_t         row_rsp
);

    typedef enum logic [2:0] {IDLE, LOAD, W_GEMM, I_GEMM, PS_GEMM} state_t;

    state_t             state, n_state;
    logic [1:0]         row, n_row;
    logic [MAT_S_W-1:0] ls_slot, in_slot, w_slot, ps_slot, rd_slot;
    logic [ADDR_W-1:0]  ls_addr;
    logic               in_here, ps_here;
    logic               row_fire, last_row;
    mat_t_t             tag;
    logic [ROW_W-1:0]   rd_data;

    function automatic logic is_mine(input logic [MAT_ID_W-1:0] id);
        return id[MAT_ID_W-1 -: BANK_W] == BANK_W'(BANK_NUM);
    endfunction

    assign idle     = (state == IDLE);
    assign row_fire = row_valid & row_ready;
    assign last_row = (row == 2'(ROWS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            row     <= '0;
            in_here <= 1'b0;
            ps_here <= 1'b0;
        end else begin
            state <= n_state;
            row   <= n_row;
            if (instr_take) begin
                in_here <= (head.opcode == OPC_GEMM) && is_mine(head.in_mat);
                ps_here <= (head.opcode == OPC_GEMM) && is_mine(head.psum_mat);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (instr_take) begin
            ls_slot <= head.ls_mat[MAT_S_W-1:0];
            ls_addr <= head.ls_addr;
            in_slot <= head.in_mat[MAT_S_W-1:0];
            w_slot  <= head.weight_mat[MAT_S_W-1:0];
            ps_slot <= head.psum_mat[MAT_S_W-1:0];
        end
    end

    // the row counter wraps to zero at the end of every section.
    always_comb begin
        n_state = state;
        n_row   = row;
        case (state)
            IDLE: begin
                if (instr_take && head.opcode == OPC_LOAD && is_mine(head.ls_mat)) begin
                    n_state = LOAD;
                end else if (instr_take && head.opcode == OPC_GEMM) begin
                    if (head.new_weight && is_mine(head.weight_mat)) begin
                        n_state = W_GEMM;
                    end else if (is_mine(head.in_mat)) begin
                        n_state = I_GEMM;
                    end else if (is_mine(head.psum_mat)) begin
                        n_state = PS_GEMM;
                    end
                end
            end
            LOAD: begin
                if (load_hit) begin
                    n_row = row + 1'b1;
                    if (last_row) begin
                        n_state = IDLE;
                    end
                end
            end
            W_GEMM: begin
                if (row_fire) begin
                    n_row = row + 1'b1;
                    if (last_row) begin
                        n_state = in_here ? I_GEMM : (ps_here ? PS_GEMM : IDLE);
                    end
                end
            end
            I_GEMM: begin
                if (row_fire) begin
                    n_row = row + 1'b1;
                    if (last_row) begin
                        n_state = ps_here ? PS_GEMM : IDLE;
                    end
                end
            end
            PS_GEMM: begin
                if (row_fire) begin
                    n_row = row + 1'b1;
                    if (last_row) begin
                        n_state = IDLE;
                    end
                end
            end
            default: n_state = IDLE;
        endcase
    end

    always_comb begin
        row_valid = 1'b0;
        rd_slot   = in_slot;
        tag       = TAG_INPUT;
        case (state)
            W_GEMM: begin
                row_valid = 1'b1;
                rd_slot   = w_slot;
                tag       = TAG_WEIGHT;
            end
            I_GEMM: begin
                row_valid = 1'b1;
            end
            PS_GEMM: begin
                row_valid = 1'b1;
                rd_slot   = ps_slot;
                tag       = TAG_PSUM;
            end
            default: row_valid = 1'b0;
        endcase
    end

    // rows are eight bytes apart in external memory.
    assign load_req.valid   = (state == LOAD);
    assign load_req.address = ls_addr + {{(ADDR_W-5){1'b0}}, row, 3'b000};

    assign row_rsp.mat_t = tag;
    assign row_rsp.mat_s = rd_slot;
    assign row_rsp.row_s = row;
    assign row_rsp.data  = rd_data;

    bank_memory bank_memory_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   ((state == LOAD) && load_hit),
        .wmat  (ls_slot),
        .wrow  (row),
        .wdata (load_data),
        .rmat  (rd_slot),
        .rrow  (row),
        .rdata (rd_data)
    );

endmodule

`default_nettype wire

/* hdl/load_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module load_arbiter
    import scratchpad_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  load_req_t            req [NUM_BANKS],
    input  logic                 arready,
    input  logic                 rvalid,
    input  logic [ROW_W-1:0]     rdata,
    input  logic [1:0]           rresp,
    output logic [NUM_BANKS-1:0] hit,
    output logic [ROW_W-1:0]     hit_data,
    output logic                 arvalid,
    output logic [ADDR_W-1:0]    araddr,
    output logic [2:0]           arprot,
    output logic                 rready
);

    typedef enum logic [1:0] {IDLE, ADDR, DATA} state_t;

    state_t            state;
    logic [BANK_W-1:0] gnt, last, cand;
    logic              found;

    // search starts at the bank after the last one served.
    always_comb begin
        cand  = last;
        found = 1'b0;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            if (!found && req[BANK_W'(last + i)].valid) begin
                cand  = BANK_W'(last + i);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            gnt   <= '0;
            last  <= BANK_W'(NUM_BANKS - 1);
        end else begin
            case (state)
                IDLE: begin
                    if (found) begin
                        gnt   <= cand;
                        last  <= cand;
                        state <= ADDR;
                    end
                end
                ADDR: if (arready) state <= DATA;
                DATA: if (rvalid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && found) begin
            araddr <= req[cand].address;
        end
    end

    assign arvalid  = (state == ADDR);
    assign arprot   = 3'b000;
    assign rready   = (state == DATA);
    assign hit_data = rdata;

    // rresp is not checked; an error response still completes the row.
    always_comb begin
        hit = '0;
        if (state == DATA && rvalid) begin
            hit[gnt] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/scratchpad_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_top
    import scratchpad_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 instr_valid,
    input  instr_t               instr,
    output logic                 instr_ready,
    input  logic                 arready,
    input  logic                 rvalid,
    input  logic [ROW_W-1:0]     rdata,
    input  logic [1:0]           rresp,
    output logic                 arvalid,
    output logic [ADDR_W-1:0]    araddr,
    output logic [2:0]           arprot,
    output logic                 rready,
    input  logic [NUM_BANKS-1:0] row_ready,
    output logic [NUM_BANKS-1:0] row_valid,
    output row_rsp_t             row_rsp [NUM_BANKS]
);

    instr_t               head;
    logic                 fifo_empty, fifo_full, take, accept_en;
    logic [NUM_BANKS-1:0] idle, hit;
    logic [ROW_W-1:0]     hit_data;
    load_req_t            load_req [NUM_BANKS];

    // input stays closed for the first cycle out of reset.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            accept_en <= 1'b0;
        end else begin
            accept_en <= 1'b1;
        end
    end

    assign instr_ready = accept_en & ~fifo_full;
    assign take        = ~fifo_empty & (&idle);

    sync_fifo #(
        .payload_t (instr_t),
        .DEPTH     (INSTR_DEPTH)
    ) instr_fifo_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .push  (instr_valid & instr_ready),
        .wdata (instr),
        .pop   (take),
        .rdata (head),
        .empty (fifo_empty),
        .full  (fifo_full)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_access_fsm #(
            .BANK_NUM (b)
        ) bank_access_fsm_i (
            .CLK        (CLK),
            .nRST       (nRST),
            .instr_take (take),
            .head       (head),
            .load_hit   (hit[b]),
            .load_data  (hit_data),
            .row_ready  (row_ready[b]),
            .idle       (idle[b]),
            .load_req   (load_req[b]),
            .row_valid  (row_valid[b]),
            .row_rsp    (row_rsp[b])
        );
    end

    load_arbiter load_arbiter_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (load_req),
        .arready  (arready),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rresp    (rresp),
        .hit      (hit),
        .hit_data (hit_data),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .arprot   (arprot),
        .rready   (rready)
    );

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // reset is held for three rising edges and released on a falling edge.
    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

/* test/scratchpad_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_assertions
    import scratchpad_pkg::*;
(
    input logic                 CLK,
    input logic                 nRST,
    input logic                 arvalid,
    input logic                 arready,
    input logic [ADDR_W-1:0]    araddr,
    input logic [NUM_BANKS-1:0] hit,
    input logic [NUM_BANKS-1:0] idle,
    input logic [NUM_BANKS-1:0] row_valid,
    input logic [NUM_BANKS-1:0] row_ready,
    input row_rsp_t             row_rsp [NUM_BANKS]
);

    int errors = 0;

    ar_stable: assert property (@(posedge CLK) disable iff (!nRST)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid or araddr changed before arready");
            errors++;
        end

    // a load hit must go to exactly one bank that is still busy loading.
    hit_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(hit) && ((hit & idle) == '0))
        else begin
            $error("a load hit went to more than one bank or to an idle bank");
            errors++;
        end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_row
        row_stable: assert property (@(posedge CLK) disable iff (!nRST)
            row_valid[b] && !row_ready[b] |=> row_valid[b] && $stable(row_rsp[b]))
            else begin
                $error("row output of bank %0d changed before row_ready", b);
                errors++;
            end
    end

endmodule

bind scratchpad_top scratchpad_assertions scratchpad_assertions_i (.*);

`default_nettype wire

/* test/scratchpad_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_tb
    import scratchpad_pkg::*;
();

    localparam int NUM_ENTRIES = 12;

    typedef struct packed {
        instr_t                     ins;
        logic [NUM_BANKS-1:0][3:0]  rows;
        logic                       rnd;
    } entry_t;

    logic                 CLK, nRST;
    logic                 instr_valid = 1'b0;
    instr_t               instr = '0;
    logic                 instr_ready;
    logic                 arready = 1'b0;
    logic                 rvalid = 1'b0;
    logic [ROW_W-1:0]     rdata = '0;
    logic [1:0]           rresp = 2'b00;
    logic                 arvalid, rready;
    logic [ADDR_W-1:0]    araddr;
    logic [2:0]           arprot;
    logic [NUM_BANKS-1:0] row_ready = '0;
    logic [NUM_BANKS-1:0] row_valid;
    row_rsp_t             row_rsp [NUM_BANKS];

    entry_t            tbl [NUM_ENTRIES];
    row_rsp_t          exp_q [NUM_BANKS][$];
    logic [ADDR_W-1:0] base_addr [2**MAT_ID_W];
    bit                loaded [2**MAT_ID_W];
    int                cum_beats [NUM_ENTRIES];
    int                cum_rows [NUM_ENTRIES][NUM_BANKS];
    int                rows_seen [NUM_BANKS];
    int                beats, sent, err_count, check_count, total_err;
    bit                rand_ready, r_busy;
    logic [ADDR_W-1:0] r_addr;
    int                r_wait;

    clock_gen clock_gen_i (
        .CLK  (CLK),
        .nRST (nRST)
    );

    scratchpad_top scratchpad_top_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arprot      (arprot),
        .rready      (rready),
        .row_ready   (row_ready),
        .row_valid   (row_valid),
        .row_rsp     (row_rsp)
    );

    function automatic instr_t make_load(input logic [MAT_ID_W-1:0] id,
                                         input logic [ADDR_W-1:0] addr);
        instr_t x;
        x = '0;
        x.opcode  = OPC_LOAD;
        x.ls_mat  = id;
        x.ls_addr = addr;
        return x;
    endfunction

    function automatic instr_t make_gemm(input logic [MAT_ID_W-1:0] w, in, ps,
                                         input logic nw);
        instr_t x;
        x = '0;
        x.opcode     = OPC_GEMM;
        x.weight_mat = w;
        x.in_mat     = in;
        x.psum_mat   = ps;
        x.new_weight = nw;
        return x;
    endfunction

    function automatic entry_t make_entry(input instr_t ins, input int r0, r1, r2, r3,
                                          input bit rnd);
        entry_t e;
        e.ins  = ins;
        e.rows = {4'(r3), 4'(r2), 4'(r1), 4'(r0)};
        e.rnd  = rnd;
        return e;
    endfunction

    function automatic int bank_of(input logic [MAT_ID_W-1:0] id);
        return int'(id[MAT_ID_W-1 -: BANK_W]);
    endfunction

    // the memory answers address A with {~A, A}; a slot never loaded still holds zeros.
    task automatic queue_section(input int b, input mat_t_t tag,
                                 input logic [MAT_ID_W-1:0] id);
        row_rsp_t          r;
        logic [ADDR_W-1:0] a;
        for (int k = 0; k < ROWS; k++) begin
            a       = base_addr[id] + ADDR_W'(8 * k);
            r.mat_t = tag;
            r.mat_s = id[MAT_S_W-1:0];
            r.row_s = 2'(k);
            r.data  = loaded[id] ? {~a, a} : '0;
            exp_q[b].push_back(r);
        end
    endtask

    task automatic build_expectations();
        instr_t ins;
        int     n0;
        int     beats_sum;
        int     rows_sum [NUM_BANKS];
        beats_sum = 0;
        rows_sum  = '{default: 0};
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ins = tbl[i].ins;
            if (ins.opcode == OPC_LOAD) begin
                base_addr[ins.ls_mat] = ins.ls_addr;
                loaded[ins.ls_mat]    = 1'b1;
                beats_sum += ROWS;
            end
            for (int b = 0; b < NUM_BANKS; b++) begin
                n0 = exp_q[b].size();
                if (ins.opcode == OPC_GEMM) begin
                    if (ins.new_weight && bank_of(ins.weight_mat) == b) begin
                        queue_section(b, TAG_WEIGHT, ins.weight_mat);
                    end
                    if (bank_of(ins.in_mat) == b) begin
                        queue_section(b, TAG_INPUT, ins.in_mat);
                    end
                    if (bank_of(ins.psum_mat) == b) begin
                        queue_section(b, TAG_PSUM, ins.psum_mat);
                    end
                end
                if (exp_q[b].size() - n0 != int'(tbl[i].rows[b])) begin
                    $display("entry %0d lists %0d rows for bank %0d but the opcode gives %0d",
                             i, tbl[i].rows[b], b, exp_q[b].size() - n0);
                    err_count++;
                end
                rows_sum[b] += int'(tbl[i].rows[b]);
                cum_rows[i][b] = rows_sum[b];
            end
            cum_beats[i] = beats_sum;
        end
    endtask

    task automatic issue_all();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            instr       = tbl[i].ins;
            instr_valid = 1'b1;
            while (!instr_ready) @(negedge CLK);
            @(negedge CLK);
            sent++;
        end
        instr_valid = 1'b0;
    endtask

    task automatic await_entries();
        bit done;
        int err_start;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            rand_ready = tbl[i].rnd;
            err_start  = err_count;
            done       = 1'b0;
            while (!done) begin
                done = (beats >= cum_beats[i]);
                for (int b = 0; b < NUM_BANKS; b++) begin
                    if (rows_seen[b] < cum_rows[i][b]) done = 1'b0;
                end
                if (!done) @(negedge CLK);
            end
            $display("entry %0d opcode %0d finished with %0d errors",
                     i, tbl[i].ins.opcode, err_count - err_start);
        end
    endtask

    // AXI4-Lite read slave with random arready and random R latency.
    always @(negedge CLK) begin
        if (nRST) begin
            if (rvalid) begin
                rvalid = 1'b0;
                r_busy = 1'b0;
                beats++;
            end else if (r_busy && rready) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata  = {~r_addr, r_addr};
                end else begin
                    r_wait--;
                end
            end
            arready = 1'($urandom % 2);
            if (arvalid && arready && !r_busy) begin
                r_addr = araddr;
                r_busy = 1'b1;
                r_wait = $urandom % 4;
                // plain unprivileged, secure data access.
                check_count++;
                if (arprot !== 3'b000) begin
                    $display("MISMATCH arprot: got %h expected %h", arprot, 3'b000);
                    err_count++;
                end
            end
        end
    end

    always @(negedge CLK) begin
        row_rsp_t e;
        if (nRST) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                row_ready[b] = rand_ready ? 1'($urandom % 2) : 1'b1;
                if (row_valid[b] && row_ready[b]) begin
                    rows_seen[b]++;
                    if (exp_q[b].size() == 0) begin
                        $display("bank %0d sent a row when none was expected", b);
                        err_count++;
                    end else begin
                        e = exp_q[b].pop_front();
                        check_count++;
                        if (row_rsp[b] !== e) begin
                            $display("MISMATCH row_rsp[%0d]: got %h expected %h",
                                     b, row_rsp[b], e);
                            err_count++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        #(NUM_ENTRIES * 200 * 8);
        $display("timeout: the run did not finish within %0d cycles", NUM_ENTRIES * 200);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int n;
        void'($urandom(19));
        tbl[0]  = make_entry(make_load(6'h03, 32'h1000_0000), 0, 0, 0, 0, 1'b0);
        tbl[1]  = make_entry(make_gemm(6'h03, 6'h13, 6'h23, 1'b1), 4, 4, 4, 0, 1'b0);
        tbl[2]  = make_entry(make_load(6'h05, 32'h0000_2000), 0, 0, 0, 0, 1'b0);
        tbl[3]  = make_entry(make_load(6'h15, 32'h3000_0100), 0, 0, 0, 0, 1'b0);
        tbl[4]  = make_entry(make_load(6'h25, 32'h0000_4000), 0, 0, 0, 0, 1'b0);
        tbl[5]  = make_entry(make_load(6'h35, 32'h8000_0f00), 0, 0, 0, 0, 1'b0);
        tbl[6]  = make_entry(make_gemm(6'h05, 6'h15, 6'h25, 1'b1), 4, 4, 4, 0, 1'b0);
        tbl[7]  = make_entry(make_gemm(6'h05, 6'h35, 6'h35, 1'b0), 0, 0, 0, 8, 1'b0);
        tbl[8]  = make_entry(make_load(6'h3a, 32'hdead_0000), 0, 0, 0, 0, 1'b1);
        tbl[9]  = make_entry(make_gemm(6'h3a, 6'h3a, 6'h05, 1'b1), 4, 0, 0, 8, 1'b1);
        tbl[10] = make_entry(make_gemm(6'h15, 6'h25, 6'h35, 1'b1), 0, 4, 4, 4, 1'b1);
        tbl[11] = make_entry('0, 0, 0, 0, 0, 1'b1);
        build_expectations();

        @(posedge nRST);
        @(negedge CLK);
        check_count++;
        if (arvalid !== 1'b0 || rready !== 1'b0 || row_valid !== '0) begin
            $display("MISMATCH arvalid/rready/row_valid after reset: got %h/%h/%h expected 0",
                     arvalid, rready, row_valid);
            err_count++;
        end
        n = 0;
        while (!instr_ready && n < 10) begin
            @(negedge CLK);
            n++;
        end
        if (!instr_ready) begin
            $display("instr_ready did not rise after reset");
            err_count++;
        end
        $display("reset checks finished with %0d errors", err_count);

        fork
            issue_all();
            await_entries();
        join
        repeat (20) @(negedge CLK);

        if (sent != NUM_ENTRIES) begin
            $display("only %0d of %0d instructions were accepted", sent, NUM_ENTRIES);
            err_count++;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (exp_q[b].size() != 0) begin
                $display("bank %0d never sent %0d expected rows", b, exp_q[b].size());
                err_count++;
            end
        end
        total_err = err_count + scratchpad_top_i.scratchpad_assertions_i.errors;
        $display("%0d checks, %0d errors", check_count, total_err);
        if (total_err == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/scratchpad_pkg.sv
hdl/sync_fifo.sv
hdl/bank_memory.sv
hdl/bank_access_fsm.sv
hdl/load_arbiter.sv
hdl/scratchpad_top.sv
test/clock_gen.sv
test/scratchpad_assertions.sv
test/scratchpad_tb.sv

/* Bender.yml */
package:
  name: scratchpad

sources:
  - hdl/scratchpad_pkg.sv
  - hdl/sync_fifo.sv
  - hdl/bank_memory.sv
  - hdl/bank_access_fsm.sv
  - hdl/load_arbiter.sv
  - hdl/scratchpad_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/scratchpad_assertions.sv
      - test/scratchpad_tb.sv
